//--- limn_config.svh
`ifndef LIMN_CONFIG_SVH
`define LIMN_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Core sizing
////////////////////////////////////////////////////////////////////////////

// Data and address width
`define LIMN_XLEN 32

// General purpose registers, r0 reads zero
`define LIMN_NREGS 32

// First instruction fetched after reset
`define LIMN_RESET_PC 32'hFFFE_0000

// Testbench memory depth in words, indexed by addr[11:2]
`define LIMN_MEM_WORDS 1024

`endif

//--- limn_pkg.sv
`default_nettype none

`include "limn_config.svh"

package limn_pkg;

    typedef logic [`LIMN_XLEN-1:0]          word_t;
    typedef logic [$clog2(`LIMN_NREGS)-1:0] regno_t;
    typedef logic [5:0]                     opcode_t;  // inst[5:0]
    typedef logic [3:0]                     func_t;    // inst[31:28]
    typedef logic [4:0]                     imm5_t;
    typedef logic [15:0]                    imm16_t;

    localparam regno_t REG_LR = 5'd31;  // Link register

    ////////////////////////////////////////////////////////////////////////////
    // Low opcode field, ? bits are don't care for casez
    ////////////////////////////////////////////////////////////////////////////
    localparam opcode_t OP_JALR       = 6'b11_1000;
    localparam opcode_t OP_J_OR_JAL   = 6'b??_?11?;  // bit 0 selects JAL
    localparam opcode_t OP_BEQ        = 6'b11_1101;
    localparam opcode_t OP_BNE        = 6'b11_0101;
    localparam opcode_t OP_BLT        = 6'b10_1101;
    localparam opcode_t OP_ADDI       = 6'b11_1100;
    localparam opcode_t OP_SUBI       = 6'b11_0100;
    localparam opcode_t OP_SLTI       = 6'b10_1100;
    localparam opcode_t OP_SLTIS      = 6'b10_0100;
    localparam opcode_t OP_ANDI       = 6'b01_1100;
    localparam opcode_t OP_XORI       = 6'b01_0100;
    localparam opcode_t OP_ORI        = 6'b00_1100;
    localparam opcode_t OP_LUI        = 6'b00_0100;
    localparam opcode_t OP_ALU_GROUP  = 6'b11_1001;
    localparam opcode_t OP_PRIV_GROUP = 6'b10_1001;
    localparam opcode_t OP_LOAD_LONG  = 6'b10_1011;  // rd = [ra + imm16]
    localparam opcode_t OP_STORE_LONG = 6'b10_1010;  // [ra + imm16] = rb

    // Group function codes
    localparam func_t G1_ADD  = 4'b0111;
    localparam func_t G1_SUB  = 4'b0110;
    localparam func_t G1_AND  = 4'b0011;
    localparam func_t G1_XOR  = 4'b0010;
    localparam func_t G1_OR   = 4'b0001;
    localparam func_t G1_NOR  = 4'b0000;
    localparam func_t G1_SLT  = 4'b0101;
    localparam func_t G1_SLTS = 4'b0100;
    localparam func_t G2_HLT  = 4'b1100;

    typedef enum logic [1:0] {
        SH_LEFT   = 2'b00,
        SH_RIGHT  = 2'b01,
        SH_ARITH  = 2'b10,
        SH_ROTATE = 2'b11
    } shmode_t;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, NOR, SLT, SLTS, LUI
    } alu_op_t;

    typedef enum logic [3:0] {
        ALU_IMM, ALU_REG, BRANCH_EQ, BRANCH_NE, BRANCH_LT,
        JUMP, JUMP_LINK, JUMP_REG, LOAD, STORE, HALT, INVALID
    } inst_class_t;

    typedef enum logic [2:0] {
        S_FETCH, S_EXECUTE, S_READ, S_WRITE, S_HALT
    } seq_state_t;

endpackage

`default_nettype wire

//--- limn_decode.sv
`default_nettype none

module limn_decode
    import limn_pkg::*;
(
    input  wire word_t  inst,
    output inst_class_t inst_class,
    output alu_op_t     alu_op,
    output shmode_t     shmode,
    output regno_t      rd,
    output regno_t      ra,
    output regno_t      rb,
    output imm5_t       imm5,
    output imm16_t      imm16,
    output word_t       branch_offset,
    output word_t       jump_target
);

    opcode_t opcode;
    func_t   func;

    ////////////////////////////////////////////////////////////////////////////
    // Fixed fields
    ////////////////////////////////////////////////////////////////////////////
    assign opcode = inst[5:0];
    assign func   = inst[31:28];
    assign shmode = shmode_t'(inst[27:26]);
    assign rd     = inst[10:6];
    assign ra     = inst[15:11];
    assign rb     = inst[20:16];
    assign imm5   = inst[31:27];
    assign imm16  = inst[31:16];

    // Word offsets, branch one is signed
    assign branch_offset = {{9{inst[31]}}, inst[31:11], 2'b00};
    assign jump_target   = {1'b0, inst[31:3], 2'b00};  // top bit comes from pc

    ////////////////////////////////////////////////////////////////////////////
    // Classification
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        inst_class = INVALID;
        alu_op     = ADD;
        casez (opcode)
            OP_JALR:     inst_class = JUMP_REG;
            OP_J_OR_JAL: inst_class = inst[0] ? JUMP_LINK : JUMP;
            OP_BEQ:      inst_class = BRANCH_EQ;
            OP_BNE:      inst_class = BRANCH_NE;
            OP_BLT:      inst_class = BRANCH_LT;
            OP_ADDI:     begin inst_class = ALU_IMM; alu_op = ADD;  end
            OP_SUBI:     begin inst_class = ALU_IMM; alu_op = SUB;  end
            OP_SLTI:     begin inst_class = ALU_IMM; alu_op = SLT;  end
            OP_SLTIS:    begin inst_class = ALU_IMM; alu_op = SLTS; end
            OP_ANDI:     begin inst_class = ALU_IMM; alu_op = AND;  end
            OP_XORI:     begin inst_class = ALU_IMM; alu_op = XOR;  end
            OP_ORI:      begin inst_class = ALU_IMM; alu_op = OR;   end
            OP_LUI:      begin inst_class = ALU_IMM; alu_op = LUI;  end
            OP_ALU_GROUP: begin
                inst_class = ALU_REG;
                case (func)
                    G1_ADD:  alu_op = ADD;
                    G1_SUB:  alu_op = SUB;
                    G1_AND:  alu_op = AND;
                    G1_XOR:  alu_op = XOR;
                    G1_OR:   alu_op = OR;
                    G1_NOR:  alu_op = NOR;
                    G1_SLT:  alu_op = SLT;
                    G1_SLTS: alu_op = SLTS;
                    default: inst_class = INVALID;  // MOV and NOP forms
                endcase
            end
            OP_PRIV_GROUP: begin
                if (func == G2_HLT) begin
                    inst_class = HALT;
                end
            end
            OP_LOAD_LONG:  inst_class = LOAD;
            OP_STORE_LONG: inst_class = STORE;
            default:       inst_class = INVALID;
        endcase
    end

endmodule

`default_nettype wire

//--- limn_regfile.sv
`default_nettype none

`include "limn_config.svh"

module limn_regfile
    import limn_pkg::*;
(
    input  wire         clk,
    input  wire         arst_n,
    input  wire regno_t raddr_a,
    input  wire regno_t raddr_b,
    output word_t       rdata_a,
    output word_t       rdata_b,
    input  wire         wen,
    input  wire regno_t waddr,
    input  wire word_t  wdata
);

    word_t regs [`LIMN_NREGS];

    // r0 is cleared by reset and never written
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `LIMN_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // Asynchronous reads
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

endmodule

`default_nettype wire

//--- limn_execute.sv
`default_nettype none

module limn_execute
    import limn_pkg::*;
(
    input  wire inst_class_t inst_class,
    input  wire alu_op_t     alu_op,
    input  wire shmode_t     shmode,
    input  wire imm5_t       imm5,
    input  wire imm16_t      imm16,
    input  wire word_t       branch_offset,
    input  wire word_t       jump_target,
    input  wire word_t       pc,
    input  wire word_t       op_a,
    input  wire word_t       op_b,
    output word_t            result,
    output word_t            next_pc,
    output word_t            mem_addr
);

    word_t       shifted;
    logic [63:0] rot_wide;
    word_t       alu_b;
    word_t       alu_out;
    word_t       pc_plus4;

    ////////////////////////////////////////////////////////////////////////////
    // Second operand
    ////////////////////////////////////////////////////////////////////////////
    assign rot_wide = {op_b, op_b} >> imm5;  // Low half is the rotation

    always_comb begin
        case (shmode)
            SH_LEFT:   shifted = op_b << imm5;
            SH_RIGHT:  shifted = op_b >> imm5;
            SH_ARITH:  shifted = word_t'($signed(op_b) >>> imm5);
            default:   shifted = rot_wide[31:0];
        endcase
    end

    assign alu_b = (inst_class == ALU_IMM) ? {16'h0000, imm16} : shifted;

    ////////////////////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (alu_op)
            ADD:     alu_out = op_a + alu_b;
            SUB:     alu_out = op_a - alu_b;
            AND:     alu_out = op_a & alu_b;
            OR:      alu_out = op_a | alu_b;
            XOR:     alu_out = op_a ^ alu_b;
            NOR:     alu_out = ~(op_a | alu_b);
            SLT:     alu_out = {31'b0, op_a < alu_b};
            SLTS:    alu_out = {31'b0, $signed(op_a) < $signed(alu_b)};
            LUI:     alu_out = op_a | {imm16, 16'h0000};
            default: alu_out = op_a + alu_b;
        endcase
    end

    assign pc_plus4 = pc + 32'd4;

    // Link value for JAL and JALR
    assign result = ((inst_class == JUMP_LINK) || (inst_class == JUMP_REG)) ?
                    pc_plus4 : alu_out;

    ////////////////////////////////////////////////////////////////////////////
    // Next PC and data address
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (inst_class)
            BRANCH_EQ: next_pc = (op_a == '0) ? pc + branch_offset : pc_plus4;
            BRANCH_NE: next_pc = (op_a != '0) ? pc + branch_offset : pc_plus4;
            BRANCH_LT: next_pc = op_a[31] ? pc + branch_offset : pc_plus4;
            JUMP,
            JUMP_LINK: next_pc = {pc[31], jump_target[30:0]};  // Stay in the same half
            JUMP_REG:  next_pc = op_a + {14'b0, imm16, 2'b00};
            default:   next_pc = pc_plus4;
        endcase
    end

    assign mem_addr = op_a + {16'h0000, imm16};

endmodule

`default_nettype wire

//--- limn_sequencer.sv
`default_nettype none

`include "limn_config.svh"

module limn_sequencer
    import limn_pkg::*;
(
    input  wire              clk,
    input  wire              arst_n,
    input  wire inst_class_t inst_class,
    input  wire regno_t      rd,
    input  wire word_t       alu_result,
    input  wire word_t       next_pc,
    input  wire word_t       mem_addr,
    input  wire word_t       store_data,
    output word_t            inst,
    output word_t            pc,
    output logic             reg_wen,
    output regno_t           reg_waddr,
    output word_t            reg_wdata,
    output word_t            addr,
    output word_t            data_out,
    output logic             we,
    output logic             cs,
    input  wire word_t       data_in,
    input  wire              rdy
);

    seq_state_t state;
    seq_state_t state_next;
    logic       active;    // Low only until the first edge after reset
    logic       mem_done;

    ////////////////////////////////////////////////////////////////////////////
    // Control registers
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= S_FETCH;
            pc     <= `LIMN_RESET_PC;
            active <= 1'b0;
        end else begin
            state  <= state_next;
            active <= 1'b1;
            if (state == S_EXECUTE) begin
                pc <= next_pc;
            end
        end
    end

    // Instruction register
    always_ff @(posedge clk) begin
        if ((state == S_FETCH) && mem_done) begin
            inst <= data_in;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            S_FETCH: begin
                if (mem_done) state_next = S_EXECUTE;
            end
            S_EXECUTE: begin
                case (inst_class)
                    LOAD:          state_next = S_READ;
                    STORE:         state_next = S_WRITE;
                    HALT, INVALID: state_next = S_HALT;
                    default:       state_next = S_FETCH;
                endcase
            end
            S_READ, S_WRITE: begin
                if (mem_done) state_next = S_FETCH;
            end
            default: state_next = S_HALT;  // Stays until reset
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Memory port
    ////////////////////////////////////////////////////////////////////////////
    assign cs = active &&
                ((state == S_FETCH) || (state == S_READ) || (state == S_WRITE));
    assign we       = (state == S_WRITE);
    assign addr     = (state == S_FETCH) ? pc : mem_addr;  // ir holds during data
    assign data_out = store_data;
    assign mem_done = cs && rdy;

    ////////////////////////////////////////////////////////////////////////////
    // Writeback
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        reg_wen = 1'b0;
        if (state == S_EXECUTE) begin
            reg_wen = (inst_class == ALU_IMM) || (inst_class == ALU_REG) ||
                      (inst_class == JUMP_LINK) || (inst_class == JUMP_REG);
        end else if (state == S_READ) begin
            reg_wen = mem_done;  // Load data arrives with rdy
        end
    end

    assign reg_waddr = (inst_class == JUMP_LINK) ? REG_LR : rd;
    assign reg_wdata = (state == S_READ) ? data_in : alu_result;

endmodule

`default_nettype wire

//--- limn_core.sv
`default_nettype none

module limn_core
    import limn_pkg::*;
(
    input  wire        clk,
    input  wire        arst_n,
    output word_t      addr,
    input  wire word_t data_in,
    output word_t      data_out,
    output logic       we,
    output logic       cs,
    input  wire        rdy
);

    word_t       inst;
    word_t       pc;
    inst_class_t inst_class;
    alu_op_t     alu_op;
    shmode_t     shmode;
    regno_t      rd;
    regno_t      ra;
    regno_t      rb;
    imm5_t       imm5;
    imm16_t      imm16;
    word_t       branch_offset;
    word_t       jump_target;
    word_t       op_a;
    word_t       op_b;
    word_t       alu_result;
    word_t       next_pc;
    word_t       mem_addr;
    logic        reg_wen;
    regno_t      reg_waddr;
    word_t       reg_wdata;

    ////////////////////////////////////////////////////////////////////////////
    // Combinational datapath
    ////////////////////////////////////////////////////////////////////////////
    limn_decode u_decode (
        .inst          (inst),
        .inst_class    (inst_class),
        .alu_op        (alu_op),
        .shmode        (shmode),
        .rd            (rd),
        .ra            (ra),
        .rb            (rb),
        .imm5          (imm5),
        .imm16         (imm16),
        .branch_offset (branch_offset),
        .jump_target   (jump_target)
    );

    limn_regfile u_regfile (
        .clk     (clk),
        .arst_n  (arst_n),
        .raddr_a (ra),
        .raddr_b (rb),
        .rdata_a (op_a),
        .rdata_b (op_b),  // Also the store data
        .wen     (reg_wen),
        .waddr   (reg_waddr),
        .wdata   (reg_wdata)
    );

    limn_execute u_execute (
        .inst_class    (inst_class),
        .alu_op        (alu_op),
        .shmode        (shmode),
        .imm5          (imm5),
        .imm16         (imm16),
        .branch_offset (branch_offset),
        .jump_target   (jump_target),
        .pc            (pc),
        .op_a          (op_a),
        .op_b          (op_b),
        .result        (alu_result),
        .next_pc       (next_pc),
        .mem_addr      (mem_addr)
    );

    // State, PC and memory port
    limn_sequencer u_sequencer (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_class (inst_class),
        .rd         (rd),
        .alu_result (alu_result),
        .next_pc    (next_pc),
        .mem_addr   (mem_addr),
        .store_data (op_b),
        .inst       (inst),
        .pc         (pc),
        .reg_wen    (reg_wen),
        .reg_waddr  (reg_waddr),
        .reg_wdata  (reg_wdata),
        .addr       (addr),
        .data_out   (data_out),
        .we         (we),
        .cs         (cs),
        .data_in    (data_in),
        .rdy        (rdy)
    );

endmodule

`default_nettype wire

//--- tb_limn_memory.sv
`default_nettype none

`include "limn_config.svh"

module tb_limn_memory
    import limn_pkg::*;
(
    input  wire        clk,
    input  wire        arst_n,
    input  wire word_t addr,
    output word_t      rdata,
    input  wire word_t wdata,
    input  wire        we,
    input  wire        cs,
    output logic       rdy
);

    timeunit 1ns;
    timeprecision 100ps;

    word_t       ram [`LIMN_MEM_WORDS];
    logic [31:0] rng_state;
    logic [1:0]  wait_left;   // Cycles until rdy for the open access
    logic        busy;
    logic        done;

    initial begin
        rng_state = 32'd75949;
        rdy       = 1'b0;
        rdata     = '0;
        wait_left = '0;
        busy      = 1'b0;
        done      = 1'b0;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Every word differs, so a stray fetch is easy to spot
    task automatic fill_pattern();
        for (int i = 0; i < `LIMN_MEM_WORDS; i++) begin
            ram[i] = 32'h5A00_0000 ^ (word_t'(i) * 32'h0003_0005);
        end
    endtask

    task automatic write_word(input int index, input word_t value);
        ram[index] = value;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Access timing
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        done = arst_n && cs && rdy;  // Completes at this edge
        if (done && we) begin
            ram[addr[11:2]] = wdata;
        end
        #1;
        if (!arst_n || !cs) begin
            rdy  = 1'b0;
            busy = 1'b0;
        end else begin
            if (!busy || done) begin
                rng_state = xorshift(rng_state);
                wait_left = rng_state[1:0];  // 0 to 3 wait cycles
                busy      = 1'b1;
            end else if (wait_left != 2'd0) begin
                wait_left = wait_left - 2'd1;
            end
            rdy = (wait_left == 2'd0);
        end
        rdata = ram[addr[11:2]];
    end

endmodule

`default_nettype wire

//--- tb_limn_core.sv
`default_nettype none

`include "limn_config.svh"

module tb_limn_core
    import limn_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic  clk;
    logic  arst_n;
    word_t addr;
    word_t mem_rdata;
    word_t mem_wdata;
    logic  we;
    logic  cs;
    logic  rdy;

    word_t exp_addr [$];
    word_t exp_data [$];
    word_t halt_addr;
    int    halt_writes;
    int    write_idx;
    int    write_errs;
    int    err_count;
    int    tests_run;
    int    tests_failed;
    int    snap;
    bit    abort;
    bit    first_seen;
    word_t first_addr;
    logic  first_we;
    word_t last_read;

    limn_core dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .addr     (addr),
        .data_in  (mem_rdata),
        .data_out (mem_wdata),
        .we       (we),
        .cs       (cs),
        .rdy      (rdy)
    );

    tb_limn_memory mem (
        .clk    (clk),
        .arst_n (arst_n),
        .addr   (addr),
        .rdata  (mem_rdata),
        .wdata  (mem_wdata),
        .we     (we),
        .cs     (cs),
        .rdy    (rdy)
    );

    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Trace loading and reporting
    ////////////////////////////////////////////////////////////////////////////
    task automatic load_trace();
        int        fd;
        int        n;
        string     line;
        bit [7:0]  kind;
        word_t     a;
        word_t     d;
        fd = $fopen("limn_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file");
            err_count++;
            abort = 1'b1;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 3 || line[0] == "/") continue;  // Comments, blanks
            n = $sscanf(line, "%c %h %h", kind, a, d);
            if (n != 3) continue;
            if (kind == "P") begin
                mem.write_word(int'(a[11:2]), d);
            end else if (kind == "W") begin
                exp_addr.push_back(a);
                exp_data.push_back(d);
            end else if (kind == "H") begin
                halt_addr   = a;
                halt_writes = int'(d);
            end
        end
        $fclose(fd);
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_count != errs_before) begin
            tests_failed++;
            $display("test %s: FAIL", name);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic check_write(input word_t a, input word_t d);
        if (write_idx >= exp_addr.size()) begin
            $display("unexpected write of %h to %h after the last expected write", d, a);
            write_errs++;
        end else begin
            if (a != exp_addr[write_idx]) begin
                $display("ERR addr write %0d expected %h got %h", write_idx,
                         exp_addr[write_idx], a);
                write_errs++;
            end
            if (d != exp_data[write_idx]) begin
                $display("ERR data_out write %0d expected %h got %h", write_idx,
                         exp_data[write_idx], d);
                write_errs++;
            end
        end
        write_idx++;
    endtask

    // Every completed access, sampled before the edge updates
    always @(posedge clk) begin
        if (arst_n && cs && rdy) begin
            if (!first_seen) begin
                first_seen = 1'b1;
                first_addr = addr;
                first_we   = we;
            end
            if (we) begin
                check_write(addr, mem_wdata);
            end else begin
                last_read = addr;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bounded waits
    ////////////////////////////////////////////////////////////////////////////
    task automatic wait_first_access();
        int n;
        n = 0;
        while (!first_seen && n < 2000) begin
            @(posedge clk);
            n++;
        end
        if (!first_seen) begin
            $display("timed out waiting for the first memory access");
            err_count++;
            abort = 1'b1;
        end
    endtask

    task automatic wait_halt_fetch();
        int n;
        n = 0;
        while (last_read != halt_addr && n < 2000) begin
            @(posedge clk);
            n++;
        end
        if (last_read != halt_addr) begin
            $display("timed out waiting for the fetch of the HLT instruction");
            err_count++;
            abort = 1'b1;
        end
    endtask

    task automatic finish_run();
        $display("%0d tests, %0d passed, %0d failed, %0d errors", tests_run,
                 tests_run - tests_failed, tests_failed, err_count);
        if (err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        write_idx    = 0;
        write_errs   = 0;
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        abort        = 1'b0;
        first_seen   = 1'b0;
        first_addr   = '0;
        first_we     = 1'b0;
        last_read    = '0;
        halt_addr    = '0;
        halt_writes  = 0;
        mem.fill_pattern();
        load_trace();

        snap = err_count;
        repeat (10) begin
            @(posedge clk);
            if (cs !== 1'b0) begin
                $display("ERR cs during reset expected %h got %h", 1'b0, cs);
                err_count++;
            end
            if (we !== 1'b0) begin
                $display("ERR we during reset expected %h got %h", 1'b0, we);
                err_count++;
            end
        end
        report_test("reset_idle", snap);
        #1 arst_n = 1'b1;

        if (!abort) begin
            snap = err_count;
            wait_first_access();
            if (!abort) begin
                if (first_addr != `LIMN_RESET_PC) begin
                    $display("ERR addr first access expected %h got %h",
                             `LIMN_RESET_PC, first_addr);
                    err_count++;
                end
                if (first_we !== 1'b0) begin
                    $display("ERR we first access expected %h got %h", 1'b0, first_we);
                    err_count++;
                end
            end
            report_test("first_fetch", snap);
        end

        if (!abort) begin
            snap = err_count;
            wait_halt_fetch();
            if (!abort) begin
                repeat (50) begin
                    @(posedge clk);
                    if (cs !== 1'b0) begin
                        $display("ERR cs after halt expected %h got %h", 1'b0, cs);
                        err_count++;
                    end
                end
            end
            report_test("halt_idle", snap);
        end

        snap = err_count;
        err_count += write_errs;
        if (!abort) begin
            if (write_idx != halt_writes) begin
                $display("ERR write_count expected %h got %h", halt_writes, write_idx);
                err_count++;
            end
            report_test("write_sequence", snap);
        end

        finish_run();
    end

endmodule

`default_nettype wire

//--- limn_trace.txt
// P addr word = program preload, W addr data = expected write in order
// H addr count = address of the HLT fetch and total number of writes
P FFFE0000 1234013C
P FFFE0004 0204002A
P FFFE0008 ABCD0204
P FFFE000C 5678420C
P FFFE0010 0208002A
P FFFE0014 00010334
P FFFE0018 F0F0631C
P FFFE001C 00FF6314
P FFFE0020 020C002A
P FFFE0024 00014424
P FFFE0028 0001452C
P FFFE002C 70048439
P FFFE0030 6408A539
P FFFE0034 28080639
P FFFE0038 1C040739
P FFFE003C 0210002A
P FFFE0040 0214002A
P FFFE0044 0218002A
P FFFE0048 021C002A
P FFFE004C 400C4139
P FFFE0050 54086339
P FFFE0054 0224002A
P FFFE0058 022C002A
P FFFE005C 0000103D
P FFFE0060 0204002A
P FFFE0064 00001035
P FFFE0068 0228002A
P FFFE006C 0000202D
P FFFE0070 0000402D
P FFFE0090 FFFC0136
P FFFE0094 0204002A
P FFFE0098 FFFC015F
P FFFE009C 023F002A
P FFFE00A0 0300042B
P FFFE00A4 0230002A
P FFFE00A8 C0000029
P FFFE00AC 0000F838
P 00000300 C0FFEE11
W 00000204 00001234
W 00000208 ABCD5678
W 0000020C 0000F00F
W 00000210 048D0001
W 00000214 FFF5432B
W 00000218 FD5E6AB3
W 0000021C 80000246
W 00000224 00000001
W 0000022C 00000001
W 00000228 ABCD5678
W 0000023F FFFE009C
W 00000230 C0FFEE11
H FFFE00A8 0000000C

//--- src.f
+incdir+.
limn_pkg.sv
limn_decode.sv
limn_regfile.sv
limn_execute.sv
limn_sequencer.sv
limn_core.sv
tb_limn_memory.sv
tb_limn_core.sv

//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator
set -e

verilator --binary --timing -f src.f --top-module tb_limn_core -o tb_limn_core_sim

./obj_dir/tb_limn_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test completed successfully" sim.log; then
    exit 0
fi
exit 1
